/* tcdm_pkg.sv */
// bus widths and vector types; addr_t is a word address and byte enables select bytes of one word
package tcdm_pkg;

  ////////////////////////////////////////////////////////////
  // bus widths
  ////////////////////////////////////////////////////////////

  localparam int unsigned AW = 16;          // word address bits
  localparam int unsigned DW = 32;          // data bits per word
  localparam int unsigned BW = DW / 8;      // one enable per byte

  // fallback for the UW module parameter
  localparam int unsigned DEFAULT_UW = 4;

  ////////////////////////////////////////////////////////////
  // vector types
  ////////////////////////////////////////////////////////////

  typedef logic [AW-1:0] addr_t;            // word address (not byte)
  typedef logic [DW-1:0] data_t;            // one bus word
  typedef logic [BW-1:0] be_t;              // byte enable vector

endpackage

/* xfer_pkg.sv */
// transfer engine types; lengths above 2**LW-1 words are not representable
package xfer_pkg;

  localparam int unsigned LW = 8;           // length counter width

  // number of words in one transfer (zero is a no-op)
  typedef logic [LW-1:0] len_t;

  // direction of a block transfer
  typedef enum logic {
    MODE_WRITE,                             // fill memory
    MODE_READ                               // read block back
  } xfer_mode_e;

  // engine sequencing states
  typedef enum logic [1:0] {
    ST_IDLE,                                // waiting for start
    ST_ISSUE,                               // requests on the bus
    ST_DRAIN,                               // read tail with last response pending
    ST_DONE                                 // one-cycle done pulse
  } xfer_state_e;

endpackage

/* tcdm_r_user_filter.sv */
// only valid where a granted read answers exactly one cycle later; bank side user is tied to zero
module tcdm_r_user_filter
  import tcdm_pkg::*;
#(
  parameter int unsigned UW = DEFAULT_UW
) (
  input  logic          clk_i,
  input  logic          rst_ni,
  input  logic          clear_i,
  input  logic          enable_i,
  // master side
  input  logic          in_req,
  input  addr_t         in_add,
  input  logic          in_wen,
  input  be_t           in_be,
  input  data_t         in_data,
  input  logic [UW-1:0] in_user,
  output logic          in_gnt,
  output logic          in_r_valid,
  output data_t         in_r_data,
  output logic [UW-1:0] in_r_user,
  // bank side
  output logic          out_req,
  output addr_t         out_add,
  output logic          out_wen,
  output be_t           out_be,
  output data_t         out_data,
  output logic [UW-1:0] out_user,
  input  logic          out_gnt,
  input  logic          out_r_valid,
  input  data_t         out_r_data
);

  logic [UW-1:0] user_q;                    // user of the last captured request

  // request path straight through with user stripped
  assign out_req  = in_req;
  assign out_add  = in_add;
  assign out_wen  = in_wen;
  assign out_be   = in_be;
  assign out_data = in_data;
  assign out_user = '0;                     // bank has no user storage

  // response path takes user from the register
  assign in_gnt     = out_gnt;
  assign in_r_valid = out_r_valid;
  assign in_r_data  = out_r_data;
  assign in_r_user  = user_q;               // lines up with r_data one cycle on

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      user_q <= '0;
    end else if (clear_i) begin
      user_q <= '0;
    end else if (enable_i && in_req) begin
      user_q <= in_user;                    // tracks held request until gnt
    end
  end

endmodule

/* tcdm_sram_bank.sv */
// NUM_WORDS must be a power of two so the address wraps on its low bits; user is not stored
module tcdm_sram_bank
  import tcdm_pkg::*;
#(
  parameter int unsigned NUM_WORDS = 256
) (
  input  logic  clk_i,
  input  logic  rst_ni,
  input  logic  req,
  input  addr_t add,
  input  logic  wen,                        // high means read
  input  be_t   be,
  input  data_t data,
  input  logic  user,
  input  logic  stall_i,                    // competing master holds the bank
  output logic  gnt,
  output logic  r_valid,
  output data_t r_data
);

  localparam int unsigned IW = $clog2(NUM_WORDS);

  data_t          mem [NUM_WORDS];
  logic  [IW-1:0] idx;
  logic           rd_gnt;
  logic           wr_gnt;
  data_t          r_data_q;
  logic           r_valid_q;

  ////////////////////////////////////////////////////////////
  // grant and decode
  ////////////////////////////////////////////////////////////

  assign gnt    = req && !stall_i;          // no arbitration beyond the stall
  assign idx    = add[IW-1:0];              // modulo NUM_WORDS
  assign rd_gnt = gnt && wen;
  assign wr_gnt = gnt && !wen;

  ////////////////////////////////////////////////////////////
  // storage
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (wr_gnt) begin
      for (int b = 0; b < BW; b++) begin
        if (be[b]) begin
          mem[idx][b*8 +: 8] <= data[b*8 +: 8];  // merge selected bytes only
        end
      end
    end
    if (rd_gnt) begin
      r_data_q <= mem[idx];                 // one-cycle read port
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      r_valid_q <= 1'b0;
    end else begin
      r_valid_q <= rd_gnt;                  // writes never answer
    end
  end

  assign r_valid = r_valid_q;
  assign r_data  = r_data_q;

endmodule

/* xfer_counter.sv */
// last flags are meaningless for a zero length; the FSM handles that case on its own
module xfer_counter
  import tcdm_pkg::*;
  import xfer_pkg::*;
(
  input  logic  clk_i,
  input  logic  rst_ni,
  input  logic  clear_i,
  input  logic  load_i,                     // start of a transfer
  input  addr_t base_i,
  input  len_t  len_i,
  input  logic  gnt_i,
  input  logic  r_valid_i,
  output addr_t add_o,
  output len_t  index_o,
  output logic  issue_last_o,
  output logic  recv_last_o
);

  addr_t add_q;                             // address of the pending request
  len_t  issue_q;                           // grants so far
  len_t  recv_q;                            // responses so far
  len_t  len_q;
  len_t  len_m1;

  assign len_m1 = len_q - len_t'(1);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      add_q   <= '0;
      issue_q <= '0;
      recv_q  <= '0;
      len_q   <= '0;
    end else if (clear_i) begin
      add_q   <= '0;
      issue_q <= '0;
      recv_q  <= '0;
      len_q   <= '0;
    end else if (load_i) begin
      add_q   <= base_i;
      issue_q <= '0;
      recv_q  <= '0;
      len_q   <= len_i;
    end else begin
      if (gnt_i) begin
        add_q   <= add_q + addr_t'(1);      // bank wraps on its low bits
        issue_q <= issue_q + len_t'(1);
      end
      if (r_valid_i) begin
        recv_q <= recv_q + len_t'(1);
      end
    end
  end

  assign add_o        = add_q;
  assign index_o      = issue_q;            // word index for fill data
  assign issue_last_o = (issue_q == len_m1);
  assign recv_last_o  = r_valid_i && (recv_q == len_m1);

endmodule

/* xfer_fsm.sv */
// start is ignored while busy; clear aborts a transfer and drops req in the same cycle
module xfer_fsm
  import xfer_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       clear_i,
  input  logic       start_i,
  input  xfer_mode_e mode_i,
  input  len_t       len_i,
  input  logic       gnt_i,
  input  logic       issue_last_i,          // current request is the final one
  input  logic       recv_last_i,           // final response this cycle
  output logic       load_o,
  output logic       req_o,
  output logic       wen_o,
  output logic       busy_o,
  output logic       done_o,
  output logic       capture_o
);

  xfer_state_e state_q;
  xfer_state_e state_d;
  xfer_mode_e  mode_q;
  logic        zero_q;                      // latched zero-length flag
  logic        accept;

  assign accept = (state_q == ST_IDLE) && start_i;

  ////////////////////////////////////////////////////////////
  // next state
  ////////////////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      ST_IDLE: begin
        if (start_i) begin
          state_d = ST_ISSUE;
        end
      end
      ST_ISSUE: begin
        if (zero_q) begin
          state_d = ST_DONE;                // nothing to issue
        end else if (gnt_i && issue_last_i) begin
          // reads still owe one response
          state_d = (mode_q == MODE_READ) ? ST_DRAIN : ST_DONE;
        end
      end
      ST_DRAIN: begin
        if (recv_last_i) begin
          state_d = ST_DONE;
        end
      end
      ST_DONE: begin
        state_d = ST_IDLE;                  // done lasts one cycle
      end
      default: begin
        state_d = ST_IDLE;
      end
    endcase
  end

  ////////////////////////////////////////////////////////////
  // state and transfer attributes
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= ST_IDLE;
      mode_q  <= MODE_WRITE;
      zero_q  <= 1'b0;
    end else if (clear_i) begin
      state_q <= ST_IDLE;
      mode_q  <= MODE_WRITE;
      zero_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      if (accept) begin
        mode_q <= mode_i;
        zero_q <= (len_i == '0);
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // outputs
  ////////////////////////////////////////////////////////////

  assign load_o    = accept;
  assign req_o     = (state_q == ST_ISSUE) && !zero_q && !clear_i;  // held until gnt
  assign wen_o     = (mode_q == MODE_READ);                         // high is read
  assign busy_o    = (state_q != ST_IDLE);
  assign done_o    = (state_q == ST_DONE);
  assign capture_o = (state_q == ST_ISSUE);                         // filter enable

endmodule

/* resp_accumulator.sv */
// sum wraps at 2**32 and the mismatch count wraps at 2**LW; write transfers leave both at zero
module resp_accumulator
  import tcdm_pkg::*;
  import xfer_pkg::*;
#(
  parameter int unsigned UW = DEFAULT_UW
) (
  input  logic          clk_i,
  input  logic          rst_ni,
  input  logic          clear_i,
  input  logic          start_i,            // accepted start only
  input  logic [UW-1:0] tag_i,
  input  logic          r_valid_i,
  input  data_t         r_data_i,
  input  logic [UW-1:0] r_user_i,
  output data_t         sum_o,
  output len_t          mismatch_o
);

  logic [UW-1:0] tag_q;                     // tag of the running transfer
  data_t         sum_q;
  len_t          mis_q;
  logic          hit;

  assign hit = (r_user_i == tag_q);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      tag_q <= '0;
      sum_q <= '0;
      mis_q <= '0;
    end else if (clear_i) begin
      tag_q <= '0;
      sum_q <= '0;
      mis_q <= '0;
    end else if (start_i) begin
      tag_q <= tag_i;
      sum_q <= '0;
      mis_q <= '0;
    end else if (r_valid_i) begin
      if (hit) begin
        sum_q <= sum_q + r_data_i;          // modulo 2**DW
      end else begin
        mis_q <= mis_q + len_t'(1);         // response tagged for someone else
      end
    end
  end

  assign sum_o      = sum_q;                // holds until next start
  assign mismatch_o = mis_q;

endmodule

/* xfer_top.sv */
// single master only; NUM_WORDS must be a power of two and mode/base/len are sampled at start
module xfer_top
  import tcdm_pkg::*;
  import xfer_pkg::*;
#(
  parameter int unsigned UW        = DEFAULT_UW,
  parameter int unsigned NUM_WORDS = 256
) (
  input  logic          clk_i,
  input  logic          rst_ni,
  input  logic          clear_i,
  input  logic          start_i,
  input  xfer_mode_e    mode_i,
  input  addr_t         base_i,
  input  len_t          len_i,
  input  be_t           be_i,
  input  data_t         fill_i,
  input  logic [UW-1:0] tag_i,
  input  logic          stall_i,            // competing master withholds gnt
  output logic          busy_o,
  output logic          done_o,
  output data_t         sum_o,
  output len_t          mismatch_o
);

  // engine control
  logic load, capture, issue_last, recv_last;
  len_t index;

  // payload captured at start
  be_t           be_q;
  data_t         fill_q;
  logic [UW-1:0] tag_q;

  // master side of the filter
  logic          m_req, m_wen, m_gnt, m_r_valid;
  addr_t         m_add;
  data_t         m_data, m_r_data;
  logic [UW-1:0] m_r_user;

  // bank side of the filter
  logic          s_req, s_wen, s_gnt, s_r_valid;
  addr_t         s_add;
  be_t           s_be;
  data_t         s_data, s_r_data;
  logic [UW-1:0] s_user;

  always_ff @(posedge clk_i) begin
    if (load) begin
      be_q   <= be_i;
      fill_q <= fill_i;
      tag_q  <= tag_i;
    end
  end

  assign m_data = fill_q + data_t'(index);  // fill plus word index

  ////////////////////////////////////////////////////////////
  // engine
  ////////////////////////////////////////////////////////////

  xfer_fsm i_fsm (
    .clk_i, .rst_ni, .clear_i, .start_i, .mode_i, .len_i,
    .gnt_i(m_gnt), .issue_last_i(issue_last), .recv_last_i(recv_last),
    .load_o(load), .req_o(m_req), .wen_o(m_wen), .busy_o, .done_o,
    .capture_o(capture)
  );

  xfer_counter i_counter (
    .clk_i, .rst_ni, .clear_i, .load_i(load), .base_i, .len_i,
    .gnt_i(m_gnt), .r_valid_i(m_r_valid), .add_o(m_add), .index_o(index),
    .issue_last_o(issue_last), .recv_last_o(recv_last)
  );

  resp_accumulator #(.UW(UW)) i_acc (
    .clk_i, .rst_ni, .clear_i, .start_i(load), .tag_i,
    .r_valid_i(m_r_valid), .r_data_i(m_r_data), .r_user_i(m_r_user),
    .sum_o, .mismatch_o
  );

  ////////////////////////////////////////////////////////////
  // one-cycle latency boundary and memory
  ////////////////////////////////////////////////////////////

  tcdm_r_user_filter #(.UW(UW)) i_filter (
    .clk_i, .rst_ni, .clear_i, .enable_i(capture),
    .in_req(m_req), .in_add(m_add), .in_wen(m_wen), .in_be(be_q),
    .in_data(m_data), .in_user(tag_q), .in_gnt(m_gnt),
    .in_r_valid(m_r_valid), .in_r_data(m_r_data), .in_r_user(m_r_user),
    .out_req(s_req), .out_add(s_add), .out_wen(s_wen), .out_be(s_be),
    .out_data(s_data), .out_user(s_user), .out_gnt(s_gnt),
    .out_r_valid(s_r_valid), .out_r_data(s_r_data)
  );

  tcdm_sram_bank #(.NUM_WORDS(NUM_WORDS)) i_bank (
    .clk_i, .rst_ni, .req(s_req), .add(s_add), .wen(s_wen), .be(s_be),
    .data(s_data), .user(s_user[0]), .stall_i,
    .gnt(s_gnt), .r_valid(s_r_valid), .r_data(s_r_data)
  );

endmodule

/* tb_xfer_top.sv */
// directed testbench for a 256-word bank; every block read here was written earlier in the run
module tb_xfer_top
  import tcdm_pkg::*;
  import xfer_pkg::*;
();

  localparam int          UW          = 4;
  localparam int          N_WORDS     = 256;
  localparam int          CLK_PERIOD  = 4;
  localparam int          TOTAL_WORDS = 168;                 // words moved by all tests
  localparam int          TIMEOUT_CYC = TOTAL_WORDS * 20 + 200;

  logic          clk_i, rst_ni, clear_i, start_i, stall_i;
  xfer_mode_e    mode_i;
  addr_t         base_i;
  len_t          len_i;
  be_t           be_i;
  data_t         fill_i;
  logic [UW-1:0] tag_i;
  logic          busy_o, done_o;
  data_t         sum_o;
  len_t          mismatch_o;

  data_t       model_mem [N_WORDS];                          // expected bank contents
  logic [19:0] lfsr_q;                                       // x^20 + x^17 + 1
  int          errors;

  xfer_top #(.UW(UW), .NUM_WORDS(N_WORDS)) dut0 (
    .clk_i, .rst_ni, .clear_i, .start_i, .mode_i, .base_i, .len_i, .be_i,
    .fill_i, .tag_i, .stall_i, .busy_o, .done_o, .sum_o, .mismatch_o
  );

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  initial begin
    #(TIMEOUT_CYC * CLK_PERIOD);
    $display("watchdog: transfers still running after %0d cycles", TIMEOUT_CYC);
    $display("Errors found");
    $finish;
  end

  ////////////////////////////////////////////////////////////
  // random source and model helpers
  ////////////////////////////////////////////////////////////

  function automatic logic lfsr_bit();
    logic fb;
    fb     = lfsr_q[19] ^ lfsr_q[16];                        // fibonacci feedback
    lfsr_q = {lfsr_q[18:0], fb};
    return fb;
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int k = 0; k < n; k++) begin
      v = {v[30:0], lfsr_bit()};                             // one step per bit
    end
    return v;
  endfunction

  function automatic logic [UW-1:0] rand_tag();
    logic [31:0] v;
    v = rand_bits(UW);
    return v[UW-1:0];
  endfunction

  function automatic int wrap_idx(input addr_t base, input int i);
    return (int'(base) + i) % N_WORDS;                       // bank wraps on low bits
  endfunction

  // start one transfer and wait for done_o while counting stall-low cycles
  task automatic run_xfer(input string name, input xfer_mode_e mode, input addr_t base,
                          input len_t len, input be_t be, input data_t fill,
                          input logic [UW-1:0] tag, input bit rnd_stall,
                          output int cycles, output int free_cyc);
    int limit;
    limit    = int'(len) * 20 + 20;
    cycles   = 0;
    free_cyc = 0;
    mode_i   = mode;
    base_i   = base;
    len_i    = len;
    be_i     = be;
    fill_i   = fill;
    tag_i    = tag;
    start_i  = 1'b1;
    @(negedge clk_i);
    start_i  = 1'b0;
    be_i     = ~be;                                          // payload must be held inside
    fill_i   = ~fill;
    tag_i    = ~tag;
    while (!done_o && cycles < limit) begin
      stall_i = rnd_stall ? lfsr_bit() : 1'b0;
      if (!stall_i) free_cyc++;
      cycles++;
      @(negedge clk_i);
    end
    stall_i = 1'b0;
    if (!done_o) begin
      $display("%s: done_o did not arrive within %0d cycles", name, limit);
      errors++;
    end
    @(negedge clk_i);                                        // back in idle with results held
  endtask

  task automatic write_block(input string name, input addr_t base, input len_t len,
                             input be_t be, input bit rnd_stall);
    int    cycles, free_cyc, a;
    data_t fill, wdata;
    fill = rand_bits(32);
    run_xfer(name, MODE_WRITE, base, len, be, fill, rand_tag(), rnd_stall, cycles, free_cyc);
    for (int i = 0; i < int'(len); i++) begin
      a     = wrap_idx(base, i);
      wdata = fill + data_t'(i);                             // fill plus word index
      for (int b = 0; b < 4; b++) begin
        if (be[b]) model_mem[a][b*8 +: 8] = wdata[b*8 +: 8];
      end
    end
    if (sum_o !== '0 || mismatch_o !== '0) begin
      $display("FAILED %s write: expected sum 0 mismatch 0 actual %h %h",
               name, sum_o, mismatch_o);
      errors++;
    end
    if (free_cyc < int'(len)) begin
      $display("FAILED %s write grant cycles: expected >= %0d actual %0d", name, len, free_cyc);
      errors++;
    end
  endtask

  task automatic read_block(input string name, input addr_t base, input len_t len,
                            input logic [UW-1:0] tag, input bit rnd_stall);
    int    cycles, free_cyc;
    data_t exp_sum;
    exp_sum = '0;
    for (int i = 0; i < int'(len); i++) begin
      exp_sum = exp_sum + model_mem[wrap_idx(base, i)];      // wraps at 2**32
    end
    run_xfer(name, MODE_READ, base, len, 4'hf, '0, tag, rnd_stall, cycles, free_cyc);
    if (sum_o !== exp_sum) begin
      $display("FAILED %s sum: expected %h actual %h", name, exp_sum, sum_o);
      errors++;
    end
    if (mismatch_o !== '0) begin
      $display("FAILED %s mismatch: expected 0 actual %0d", name, mismatch_o);
      errors++;
    end
    if (free_cyc < int'(len)) begin
      $display("FAILED %s read grant cycles: expected >= %0d actual %0d", name, len, free_cyc);
      errors++;
    end
  endtask

  ////////////////////////////////////////////////////////////
  // directed tests
  ////////////////////////////////////////////////////////////

  task automatic test_write_read();
    write_block("write_read", 16'h0010, 8'd16, 4'hf, 1'b0);
    read_block("write_read", 16'h0010, 8'd16, rand_tag(), 1'b0);
  endtask

  task automatic test_partial_be();
    write_block("partial_be", 16'h0040, 8'd8, 4'hf, 1'b0);   // defined base data
    write_block("partial_be", 16'h0040, 8'd8, 4'b0101, 1'b0);
    write_block("partial_be", 16'h0040, 8'd8, 4'b1000, 1'b0);
    read_block("partial_be", 16'h0040, 8'd8, rand_tag(), 1'b0);
  endtask

  task automatic test_random_stall();
    write_block("random_stall", 16'h0080, 8'd20, 4'hf, 1'b1);
    read_block("random_stall", 16'h0080, 8'd20, rand_tag(), 1'b1);
  endtask

  task automatic test_tag_change();
    logic [UW-1:0] tag;
    tag = rand_tag();
    for (int k = 0; k < 4; k++) begin
      tag = tag + 1'b1;                                      // new tag every read
      read_block("tag_change", 16'h0010, 8'd6, tag, k == 3);
    end
  endtask

  task automatic test_zero_clear();
    int cycles, free_cyc;
    run_xfer("zero_len", MODE_READ, 16'h0010, 8'd0, 4'hf, '0, rand_tag(), 1'b0,
             cycles, free_cyc);
    if (cycles != 1 || sum_o !== '0) begin
      $display("FAILED zero_len: expected 1 cycle sum 0 actual %0d %h", cycles, sum_o);
      errors++;
    end
    mode_i  = MODE_READ;
    base_i  = 16'h0010;
    len_i   = 8'd10;
    start_i = 1'b1;
    @(negedge clk_i);
    start_i = 1'b0;
    repeat (3) @(negedge clk_i);                             // reads in flight
    if (!busy_o) begin
      $display("clear_busy: transfer was not busy before the clear");
      errors++;
    end
    clear_i = 1'b1;
    @(negedge clk_i);
    clear_i = 1'b0;
    if (busy_o || done_o || sum_o !== '0 || mismatch_o !== '0) begin
      $display("clear_busy: clear left busy, done or results set");
      errors++;
    end
    @(negedge clk_i);
  endtask

  task automatic test_wrap();
    write_block("wrap", addr_t'(N_WORDS - 6), 8'd12, 4'hf, 1'b0);
    read_block("wrap", addr_t'(2 * N_WORDS - 6), 8'd12, rand_tag(), 1'b0);  // aliased base
    read_block("wrap", 16'h0000, 8'd6, rand_tag(), 1'b0);    // wrapped tail
  endtask

  ////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////

  initial begin
    lfsr_q  = 20'd93258;
    errors  = 0;
    rst_ni  = 1'b0;
    clear_i = 1'b0;
    start_i = 1'b0;
    stall_i = 1'b0;
    mode_i  = MODE_WRITE;
    base_i  = '0;
    len_i   = '0;
    be_i    = '0;
    fill_i  = '0;
    tag_i   = '0;
    repeat (4) @(negedge clk_i);
    rst_ni = 1'b1;
    @(negedge clk_i);
    if (busy_o || done_o || sum_o !== '0 || mismatch_o !== '0) begin
      $display("reset: outputs not at their reset values");
      errors++;
    end
    test_write_read();
    test_partial_be();
    test_random_stall();
    test_tag_change();
    test_zero_clear();
    test_wrap();
    $display("tests finished with %0d errors", errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

/* sources.f */
tcdm_pkg.sv
xfer_pkg.sv
tcdm_r_user_filter.sv
tcdm_sram_bank.sv
xfer_counter.sv
xfer_fsm.sv
resp_accumulator.sv
xfer_top.sv
tb_xfer_top.sv

/* Makefile */
# Verilator build and run of the transfer engine testbench

VERILATOR ?= verilator
TOP       ?= tb_xfer_top
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing

.PHONY: sim clean

# build, run, then pass only if the log holds the pass message
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "No errors" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
